// ==== sim/mf2_cases.txt ====
# op        addr  data  mode  expect   (all numbers hex; mode 0 enabled, 2 disabled)
# expect: reset {nmi,paged,rom_sel,ram_sel}, read data, write/io/fetch paged, sel {rom_sel,ram_sel}
reset       0000  00    0     00
read        0000  00    0     ff
read        2000  00    0     ff
read        9c40  00    0     ff
key         0000  00    0     00
wait_nmi    0000  00    0     01
fetch       0066  00    0     01
wait_nmi    0000  00    0     00
sel         0100  00    0     02
write       2000  5a    0     01
write       3abc  c3    0     01
read        2000  00    0     5a
read        3abc  00    0     c3
read        4000  00    0     ff
io          7f05  03    0     01
io          7f00  4a    0     01
read        3fcf  00    0     03
read        3f93  00    0     4a
io          bc00  07    0     01
io          bd00  22    0     01
read        3db7  00    0     22
io          feea  00    0     00
io          fee8  00    0     01
fetch       0065  00    0     01
io          feea  00    0     00
io          fee8  00    0     00
reset       0000  00    2     00
key         0000  00    2     00
stay_nmi    0000  00    2     00

// ==== compile.f ====
source/mf2_pkg.sv
source/cpu_bus_if.sv
source/mf2_io_decode.sv
source/mf2_control.sv
source/mf2_ram.sv
source/multiface_two.sv
sim/mf2_clock.sv
sim/mf2_properties.sv
sim/mf2_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Multiface Two testbench with Verilator, then check the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module mf2_tb \
	-Mdir obj_dir -f compile.f \
	&& ./obj_dir/Vmf2_tb > sim.log 2>&1 \
	|| echo "Finished with errors" >> sim.log
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
exit 0

// ==== sim/mf2_tb.sv ====
`timescale 1ns/1ns

module mf2_tb;
	import mf2_pkg::*;

	logic              clk_sys;
	logic              reset;
	logic              restart;
	logic [addr_w-1:0] cpu_addr;
	logic [data_w-1:0] cpu_dout;
	logic              io_wr;
	logic              mem_wr;
	logic              mem_rd;
	logic              m1;
	logic              key_nmi;
	mf2_mode_e         mode;
	logic              nmi;
	logic              paged;
	logic              rom_sel;
	logic              ram_sel;
	logic [data_w-1:0] dout;

	int errors;
	int tests;

	mf2_clock clock_i (
		.restart (restart),
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	multiface_two dut_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.io_wr    (io_wr),
		.mem_wr   (mem_wr),
		.mem_rd   (mem_rd),
		.m1       (m1),
		.key_nmi  (key_nmi),
		.mode     (mode),
		.nmi      (nmi),
		.paged    (paged),
		.rom_sel  (rom_sel),
		.ram_sel  (ram_sel),
		.dout     (dout)
	);

	//////////////////////////////////////////////////
	// Bus helpers
	//////////////////////////////////////////////////

	// Drive point, 10 ns after the rising edge
	task automatic step_cycle;
		@(posedge clk_sys);
		#10;
	endtask

	task automatic report_fail(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic apply_reset(input logic [3:0] expect_lvl);
		int cycles;
		step_cycle();
		restart = 1'b1;
		step_cycle();
		restart = 1'b0;
		cycles = 0;
		while (reset && cycles < 20) begin
			step_cycle();
			cycles++;
		end
		if (reset) begin
			$display("Reset did not release within 20 cycles");
			errors++;
		end else if ({nmi, paged, rom_sel, ram_sel} !== expect_lvl) begin
			report_fail($sformatf("after reset nmi,paged,rom_sel,ram_sel = %b%b%b%b",
				nmi, paged, rom_sel, ram_sel));
		end
	endtask

	// Strobe held for two edges, then three quiet cycles
	task automatic strobe_bus(input string op, input logic [addr_w-1:0] a,
		input logic [data_w-1:0] d);
		step_cycle();
		cpu_addr = a;
		cpu_dout = d;
		if (op == "write")
			mem_wr = 1'b1;
		else if (op == "io")
			io_wr = 1'b1;
		else if (op == "fetch")
			m1 = 1'b1;
		else
			key_nmi = 1'b1;
		repeat (2) step_cycle();
		mem_wr = 1'b0;
		io_wr = 1'b0;
		m1 = 1'b0;
		key_nmi = 1'b0;
		repeat (3) step_cycle();
	endtask

	task automatic read_back(input logic [addr_w-1:0] a, input logic [data_w-1:0] expected);
		step_cycle();
		cpu_addr = a;
		mem_rd = 1'b1;
		repeat (3) step_cycle();
		if (dout !== expected)
			report_fail($sformatf("read %h gave %h, expected %h", a, dout, expected));
		mem_rd = 1'b0;
	endtask

	task automatic wait_for_nmi(input logic level);
		int cycles;
		cycles = 0;
		while (nmi !== level && cycles < 20) begin
			step_cycle();
			cycles++;
		end
		if (nmi !== level) begin
			$display("Timeout: nmi did not go to %b within 20 cycles", level);
			errors++;
		end
	endtask

	// nmi must keep its level for the whole timeout
	task automatic watch_nmi(input logic level);
		int cycles;
		cycles = 0;
		while (nmi === level && cycles < 20) begin
			step_cycle();
			cycles++;
		end
		if (nmi !== level)
			report_fail($sformatf("nmi left %b after %0d cycles", level, cycles));
	endtask

	task automatic check_select(input logic [addr_w-1:0] a, input logic [1:0] expected);
		step_cycle();
		cpu_addr = a;
		step_cycle();
		if ({rom_sel, ram_sel} !== expected)
			report_fail($sformatf("address %h gave rom_sel,ram_sel %b%b, expected %b",
				a, rom_sel, ram_sel, expected));
	endtask

	//////////////////////////////////////////////////
	// Case file runner
	//////////////////////////////////////////////////

	initial begin
		int                fd;
		int                fields;
		int                errors_before;
		string             line;
		string             op_name;
		logic [addr_w-1:0] f_addr;
		logic [data_w-1:0] f_data;
		logic [7:0]        f_mode;
		logic [7:0]        f_expect;

		restart = 1'b0;
		cpu_addr = '0;
		cpu_dout = '0;
		io_wr = 1'b0;
		mem_wr = 1'b0;
		mem_rd = 1'b0;
		m1 = 1'b0;
		key_nmi = 1'b0;
		mode = mode_enabled;
		errors = 0;
		tests = 0;

		fd = $fopen("sim/mf2_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the case file sim/mf2_cases.txt");
			errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				fields = $sscanf(line, "%s %h %h %h %h", op_name, f_addr, f_data, f_mode,
					f_expect);
				if (fields != 5) begin
					$display("Malformed line in the case file: %s", line);
					errors++;
					continue;
				end
				errors_before = errors;
				mode = mf2_mode_e'(f_mode[1:0]);
				if (op_name == "reset") begin
					apply_reset(f_expect[3:0]);
				end else if (op_name == "read") begin
					read_back(f_addr, f_expect);
				end else if (op_name == "write" || op_name == "io" || op_name == "fetch") begin
					strobe_bus(op_name, f_addr, f_data);
					if (paged !== f_expect[0])
						report_fail($sformatf("%s %h left paged %b", op_name, f_addr, paged));
				end else if (op_name == "key") begin
					strobe_bus(op_name, f_addr, f_data);
				end else if (op_name == "wait_nmi") begin
					wait_for_nmi(f_expect[0]);
				end else if (op_name == "stay_nmi") begin
					watch_nmi(f_expect[0]);
				end else if (op_name == "sel") begin
					check_select(f_addr, f_expect[1:0]);
				end else begin
					$display("Unknown operation %s in the case file", op_name);
					errors++;
				end
				tests++;
				$display("Test %0d %s %h: %s", tests, op_name, f_addr,
					errors == errors_before ? "ok" : "failed");
			end
			$fclose(fd);
		end

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== sim/mf2_properties.sv ====
`timescale 1ns/1ns

module mf2_properties (
	input logic                        clk_sys,
	input logic                        reset,
	input mf2_pkg::mf2_io_op_e         io_op,
	input logic                        fetch_rise,
	input logic                        m1,
	input logic [mf2_pkg::addr_w-1:0]  addr,
	input logic                        nmi,
	input logic                        paged
);
	import mf2_pkg::*;

	logic page_cause;
	logic m1_prev;
	logic vector_fetch;

	assign page_cause = fetch_rise || io_op == io_page_in;

	always_ff @(posedge clk_sys)
		m1_prev <= m1;

	// Opcode fetch at the NMI vector as seen on the CPU bus
	assign vector_fetch = m1 && !m1_prev && addr == nmi_vector;

	// Both come from one FSM state
	nmi_not_paged: assert property (@(posedge clk_sys) disable iff (reset)
		!(nmi && paged))
		else $error("nmi and paged are high together");

	// Paging in needs a fetch or a page-in command just before
	paged_has_cause: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(paged) |-> $past(page_cause, 1) || $past(page_cause, 2))
		else $error("paged rose without a fetch or page-in command");

	nmi_taken: assert property (@(posedge clk_sys) disable iff (reset)
		$past(vector_fetch && nmi, 2) |-> !nmi)
		else $error("nmi still high two cycles after the vector fetch");

endmodule

bind mf2_control mf2_properties props_i (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.io_op      (io_op),
	.fetch_rise (fetch_rise),
	.m1         (bus.m1),
	.addr       (bus.addr),
	.nmi        (nmi),
	.paged      (paged)
);

// ==== sim/mf2_clock.sv ====
`timescale 1ns/1ns

// Free running 100 ns clock and a three cycle reset, restarted on request
module mf2_clock (
	input  logic restart,
	output logic clk_sys,
	output logic reset
);
	int reset_cnt = 3;

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		if (restart)
			reset_cnt <= 3;
		else if (reset_cnt > 0)
			reset_cnt <= reset_cnt - 1;
	end

	assign reset = reset_cnt != 0;

endmodule

// ==== source/multiface_two.sv ====
`timescale 1ns/1ns

module multiface_two (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic [mf2_pkg::addr_w-1:0]  cpu_addr,
	input  logic [mf2_pkg::data_w-1:0]  cpu_dout,
	input  logic                        io_wr,
	input  logic                        mem_wr,
	input  logic                        mem_rd,
	input  logic                        m1,
	input  logic                        key_nmi,
	input  mf2_pkg::mf2_mode_e          mode,
	output logic                        nmi,
	output logic                        paged,
	output logic                        rom_sel,
	output logic                        ram_sel,
	output logic [mf2_pkg::data_w-1:0]  dout
);
	import mf2_pkg::*;

	mf2_io_op_e            io_op;
	logic [ram_addr_w-1:0] store_addr;

	//////////////////////////////////////////////////
	// CPU bus bundle
	//////////////////////////////////////////////////

	cpu_bus_if bus_i ();

	assign bus_i.addr   = cpu_addr;
	assign bus_i.dout   = cpu_dout;
	assign bus_i.io_wr  = io_wr;
	assign bus_i.mem_wr = mem_wr;
	assign bus_i.mem_rd = mem_rd;
	assign bus_i.m1     = m1;

	mf2_io_decode decode_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus_i),
		.io_op      (io_op),
		.store_addr (store_addr)
	);

	mf2_control control_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus_i),
		.key_nmi (key_nmi),
		.mode    (mode),
		.io_op   (io_op),
		.nmi     (nmi),
		.paged   (paged)
	);

	// Paged level opens the RAM window
	mf2_ram ram_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus_i),
		.paged      (paged),
		.io_op      (io_op),
		.store_addr (store_addr),
		.dout       (dout),
		.rom_sel    (rom_sel),
		.ram_sel    (ram_sel)
	);

endmodule

// ==== source/mf2_ram.sv ====
`timescale 1ns/1ns

module mf2_ram (
	input  logic                           clk_sys,
	input  logic                           reset,
	cpu_bus_if.ram                         bus,
	input  logic                           paged,
	input  mf2_pkg::mf2_io_op_e            io_op,
	input  logic [mf2_pkg::ram_addr_w-1:0] store_addr,
	output logic [mf2_pkg::data_w-1:0]     dout,
	output logic                           rom_sel,
	output logic                           ram_sel
);
	import mf2_pkg::*;

	logic [data_w-1:0]     mem [2**ram_addr_w];
	logic [ram_addr_w-1:0] ram_a;
	logic [data_w-1:0]     ram_in;
	logic [data_w-1:0]     ram_out;
	logic                  ram_we;

	// Cartridge ROM at 0000-1FFF, RAM at 2000-3FFF
	assign rom_sel = paged && bus.addr[addr_w-1:ram_addr_w] == 3'd0;
	assign ram_sel = paged && bus.addr[addr_w-1:ram_addr_w] == 3'd1;

	//////////////////////////////////////////////////
	// Write source select
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		ram_in <= bus.dout;
		ram_a  <= bus.addr[ram_addr_w-1:0];
		// Shadow store wins over a CPU write in the window
		if (io_op == io_store)
			ram_a <= store_addr;
		if (reset)
			ram_we <= 1'b0;
		else
			ram_we <= io_op == io_store || (bus.mem_wr && ram_sel);
	end

	// Write-first, the read port shows the byte just written
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_a] <= ram_in;
			ram_out    <= ram_in;
		end else begin
			ram_out <= mem[ram_a];
		end
	end

	// FF floats the bus when the cartridge is not selected
	assign dout = (ram_sel && bus.mem_rd) ? ram_out : '1;

endmodule

// ==== source/mf2_control.sv ====
`timescale 1ns/1ns

module mf2_control (
	input  logic                clk_sys,
	input  logic                reset,
	cpu_bus_if.control          bus,
	input  logic                key_nmi,
	input  mf2_pkg::mf2_mode_e  mode,
	input  mf2_pkg::mf2_io_op_e io_op,
	output logic                nmi,
	output logic                paged
);
	import mf2_pkg::*;

	mf2_state_e        state;
	logic              hidden;
	logic              key_nmi_q;
	logic              key_nmi_qq;
	logic              m1_q;
	logic              m1_qq;
	logic [addr_w-1:0] addr_q;
	logic              key_rise;
	logic              fetch_rise;
	logic              nmi_fetch;
	logic              hide_fetch;

	// Sample stage, edges come from the two registered copies
	always_ff @(posedge clk_sys) begin
		addr_q <= bus.addr;
		if (reset) begin
			key_nmi_q  <= 1'b0;
			key_nmi_qq <= 1'b0;
			m1_q       <= 1'b0;
			m1_qq      <= 1'b0;
		end else begin
			key_nmi_q  <= key_nmi;
			key_nmi_qq <= key_nmi_q;
			m1_q       <= bus.m1;
			m1_qq      <= m1_q;
		end
	end

	assign key_rise   = key_nmi_q & ~key_nmi_qq;
	assign fetch_rise = m1_q & ~m1_qq;
	assign nmi_fetch  = fetch_rise && addr_q == nmi_vector;
	assign hide_fetch = fetch_rise && addr_q == hide_vector;

	//////////////////////////////////////////////////
	// Paging FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= st_off;
			hidden <= mode != mode_enabled;
		end else begin
			case (state)
				st_off: begin
					if (io_op == io_page_in && !hidden)
						state <= st_paged;
					else if (key_rise && mode != mode_disabled)
						state <= st_nmi_pending;
				end
				st_nmi_pending: begin
					// Vector fetch is the CPU taking the NMI
					if (nmi_fetch) begin
						state  <= st_paged;
						hidden <= 1'b0;
					end else if (io_op == io_page_in && !hidden) begin
						state <= st_paged;
					end
				end
				st_paged: begin
					if (hide_fetch)
						hidden <= 1'b1;
					if (io_op == io_page_out)
						state <= st_off;
				end
				default: state <= st_off;
			endcase
		end
	end

	assign nmi   = state == st_nmi_pending;
	assign paged = state == st_paged;

endmodule

// ==== source/mf2_io_decode.sv ====
`timescale 1ns/1ns

module mf2_io_decode (
	input  logic                           clk_sys,
	input  logic                           reset,
	cpu_bus_if.decode                      bus,
	output mf2_pkg::mf2_io_op_e            io_op,
	output logic [mf2_pkg::ram_addr_w-1:0] store_addr
);
	import mf2_pkg::*;

	logic                  io_wr_q;
	logic                  io_wr_rise;
	logic [7:0]            port_hi;
	logic [1:0]            ga_func;
	logic                  page_hit;
	logic                  store_hit;
	logic [ram_addr_w-1:0] store_next;
	// Last pen selected on the gate array, bit 4 picks the border
	logic [4:0]            pen_index;
	// Last CRTC register number written to BC
	logic [3:0]            crtc_reg;

	assign io_wr_rise = bus.io_wr & ~io_wr_q;
	assign port_hi    = bus.addr[addr_w-1:addr_w-8];
	assign ga_func    = bus.dout[7:6];
	assign page_hit   = bus.addr[addr_w-1:2] == page_port_base[addr_w-1:2];

	//////////////////////////////////////////////////
	// Store address table
	//////////////////////////////////////////////////

	always_comb begin
		store_hit  = 1'b1;
		store_next = '0;
		case (port_hi)
			port_gate_array: begin
				// Gate array function is in the top two data bits
				case (ga_func)
					2'b00: store_next = store_pen_index;
					2'b01: begin
						if (pen_index[4])
							store_next = store_border;
						else
							store_next = {store_pen_base[ram_addr_w-1:4], pen_index[3:0]};
					end
					2'b10: store_next = store_mode;
					default: store_next = store_banking;
				endcase
			end
			port_crtc_select: store_next = store_crtc_select;
			port_crtc_data:   store_next = {store_crtc_base[ram_addr_w-1:4], crtc_reg};
			port_ppi:         store_next = store_ppi;
			port_rom:         store_next = store_rom;
			default:          store_hit = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////
	// One op per io_wr rising edge
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			io_op   <= io_none;
		end else begin
			io_wr_q <= bus.io_wr;
			io_op   <= io_none;
			if (io_wr_rise) begin
				if (page_hit)
					io_op <= bus.addr[1] ? io_page_out : io_page_in;
				else if (store_hit)
					io_op <= io_store;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		store_addr <= store_next;
		if (io_wr_rise) begin
			if (port_hi == port_gate_array && ga_func == 2'b00)
				pen_index <= bus.dout[4:0];
			if (port_hi == port_crtc_select)
				crtc_reg <= bus.dout[3:0];
		end
	end

endmodule

// ==== source/cpu_bus_if.sv ====
`timescale 1ns/1ns

// CPU side of the expansion bus as the cartridge sees it
interface cpu_bus_if;
	import mf2_pkg::*;

	logic [addr_w-1:0] addr;
	logic [data_w-1:0] dout;
	logic              io_wr;
	logic              mem_wr;
	logic              mem_rd;
	// Opcode fetch cycle
	logic              m1;

	modport decode (
		input addr,
		input dout,
		input io_wr
	);

	modport control (input addr, input m1);

	modport ram (input addr, input dout, input mem_wr, input mem_rd);

endinterface

// ==== source/mf2_pkg.sv ====
package mf2_pkg;

	//////////////////////////////////////////////////
	// Bus and RAM widths
	//////////////////////////////////////////////////

	localparam int addr_w     = 16;
	localparam int data_w     = 8;
	localparam int ram_addr_w = 13;

	// Fetch vectors and the FEE8/FEEA page ports
	localparam logic [addr_w-1:0] nmi_vector     = 16'h0066;
	localparam logic [addr_w-1:0] hide_vector    = 16'h0065;
	localparam logic [addr_w-1:0] page_port_base = 16'hFEE8;

	//////////////////////////////////////////////////
	// Shadow store slots in cartridge RAM
	//////////////////////////////////////////////////

	localparam logic [ram_addr_w-1:0] store_pen_index   = 13'h1FCF;
	localparam logic [ram_addr_w-1:0] store_pen_base    = 13'h1F90;
	localparam logic [ram_addr_w-1:0] store_border      = 13'h1FDF;
	localparam logic [ram_addr_w-1:0] store_mode        = 13'h1FEF;
	localparam logic [ram_addr_w-1:0] store_banking     = 13'h1FFF;
	localparam logic [ram_addr_w-1:0] store_crtc_select = 13'h1CFF;
	localparam logic [ram_addr_w-1:0] store_crtc_base   = 13'h1DB0;
	localparam logic [ram_addr_w-1:0] store_ppi         = 13'h17FF;
	localparam logic [ram_addr_w-1:0] store_rom         = 13'h1AAC;

	// High byte of the I/O address for each shadowed chip
	localparam logic [7:0] port_gate_array  = 8'h7F;
	localparam logic [7:0] port_crtc_select = 8'hBC;
	localparam logic [7:0] port_crtc_data   = 8'hBD;
	localparam logic [7:0] port_ppi         = 8'hF7;
	localparam logic [7:0] port_rom         = 8'hDF;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {mode_enabled, mode_hidden, mode_disabled} mf2_mode_e;

	typedef enum logic [1:0] {io_none, io_page_in, io_page_out, io_store} mf2_io_op_e;

	typedef enum logic [1:0] {st_off, st_nmi_pending, st_paged} mf2_state_e;

endpackage
